// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_eth_mmio_bridge
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/axi4lite_pkg.sv ====
package axi4lite_pkg;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam int bus_width = 64;
    // Byte offset bits within a register that decode ignores
    localparam int word_shift = 3;
    localparam int num_regs = 6;

    // Register indices
    localparam int reg_src_mac = 0;
    localparam int reg_dst_type = 1;
    localparam int reg_tx_data = 2;
    localparam int reg_rx_src = 3;
    localparam int reg_rx_dst_type = 4;
    localparam int reg_rx_data = 5;

endpackage

// ==== common/eth_pkg.sv ====
package eth_pkg;

    // Ethernet header fields
    localparam int mac_width = 48;
    localparam int type_width = 16;
    localparam int hdr_bytes = 14;

    // Payload carried by one 64-bit data word
    localparam int word_bytes = 7;
    localparam int data_width = 56;
    localparam int count_width = 3;

    // Data word layout with payload byte 0 in the lowest data byte
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic [2:0]             reserved;
        logic [count_width-1:0] count;
        logic [data_width-1:0]  data;
    } eth_word_fields_t;

    // Same bus word seen either raw or split into fields
    typedef union packed {
        logic [$bits(eth_word_fields_t)-1:0] raw;
        eth_word_fields_t                    fields;
    } eth_mmio_word_u;

endpackage

// ==== mmio/eth_mmio_regs.sv ====
`timescale 1ns/1ps

module eth_mmio_regs #(
    parameter int addr_width = 12
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [addr_width-1:0]                 awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [axi4lite_pkg::bus_width-1:0]    wdata,
    input  logic [axi4lite_pkg::bus_width/8-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [addr_width-1:0]                 araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [axi4lite_pkg::bus_width-1:0]    rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [eth_pkg::mac_width-1:0]         hdr_dst_mac,
    output logic [eth_pkg::mac_width-1:0]         hdr_src_mac,
    output logic [eth_pkg::type_width-1:0]        hdr_type,
    output logic                                  tx_word_valid,
    output logic [eth_pkg::data_width-1:0]        tx_word_data,
    output logic [eth_pkg::count_width-1:0]       tx_word_count,
    output logic                                  tx_word_last,
    input  logic                                  tx_word_ready,
    input  logic                                  rx_word_valid,
    input  logic [eth_pkg::data_width-1:0]        rx_word_data,
    input  logic [eth_pkg::count_width-1:0]       rx_word_count,
    input  logic                                  rx_word_last,
    input  logic                                  rx_word_first,
    input  logic [eth_pkg::mac_width-1:0]         rx_hdr_dst_mac,
    input  logic [eth_pkg::mac_width-1:0]         rx_hdr_src_mac,
    input  logic [eth_pkg::type_width-1:0]        rx_hdr_type,
    output logic                                  rx_word_ready
);
    import eth_pkg::*;
    import axi4lite_pkg::*;

    localparam int idx_width = $clog2(num_regs);

    // Upper address bits must be zero and the index must be in the map
    function automatic logic addr_bad(input logic [addr_width-1:0] addr);
        return (addr >> (word_shift + idx_width)) != '0 ||
               addr[word_shift +: idx_width] >= num_regs;
    endfunction

    logic                 aw_held;
    logic                 w_held;
    logic [idx_width-1:0] aw_idx_q;
    logic                 aw_bad_q;
    logic [bus_width-1:0] wdata_q;
    logic                 aw_hs;
    logic                 w_hs;
    logic [idx_width-1:0] wr_idx;
    logic                 wr_bad;
    logic                 wr_both;
    logic                 wr_is_tx;
    logic                 wr_fire;
    eth_mmio_word_u       wr_word;

    logic                  ar_hs;
    logic [idx_width-1:0]  rd_idx;
    logic                  rd_bad;
    logic [mac_width-1:0]  rx_src_q;
    logic [mac_width-1:0]  rx_dst_q;
    logic [type_width-1:0] rx_type_q;
    eth_mmio_word_u        rx_word;

    // Each beat is taken once and held until the response handshake
    assign awready = !aw_held;
    assign wready = !w_held;
    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;

    assign wr_idx = aw_held ? aw_idx_q : awaddr[word_shift +: idx_width];
    assign wr_bad = aw_held ? aw_bad_q : addr_bad(awaddr);
    assign wr_both = (aw_held || aw_hs) && (w_held || w_hs) && !bvalid;
    assign wr_is_tx = !wr_bad && wr_idx == reg_tx_data;
    // A transmit word completes only when the framer takes it
    assign wr_fire = wr_both && (!wr_is_tx || tx_word_ready);

    always_comb begin
        wr_word.raw = w_held ? wdata_q : wdata;
    end

    assign tx_word_valid = wr_both && wr_is_tx;
    assign tx_word_data = wr_word.fields.data;
    assign tx_word_count = wr_word.fields.count;
    assign tx_word_last = wr_word.fields.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            hdr_src_mac <= '0;
            hdr_dst_mac <= '0;
            hdr_type <= '0;
        end else begin
            if (aw_hs) begin
                aw_held <= 1'b1;
            end
            if (w_hs) begin
                w_held <= 1'b1;
            end
            if (bvalid && bready) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (!wr_bad && wr_idx == reg_src_mac) begin
                    hdr_src_mac <= wr_word.raw[mac_width-1:0];
                end
                if (!wr_bad && wr_idx == reg_dst_type) begin
                    hdr_type <= wr_word.raw[bus_width-1 -: type_width];
                    hdr_dst_mac <= wr_word.raw[mac_width-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_idx_q <= awaddr[word_shift +: idx_width];
            aw_bad_q <= addr_bad(awaddr);
        end
        if (w_hs) begin
            wdata_q <= wdata;
        end
        if (wr_fire) begin
            bresp <= wr_bad ? resp_slverr : resp_okay;
        end
    end

    // Read side allows one read outstanding
    assign arready = !rvalid;
    assign ar_hs = arvalid && arready;
    assign rd_idx = araddr[word_shift +: idx_width];
    assign rd_bad = addr_bad(araddr);
    assign rx_word_ready = ar_hs && !rd_bad && rd_idx == reg_rx_data && rx_word_valid;

    always_comb begin
        rx_word.fields.valid = 1'b1;
        rx_word.fields.last = rx_word_last;
        rx_word.fields.reserved = '0;
        rx_word.fields.count = rx_word_count;
        rx_word.fields.data = rx_word_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            rx_src_q <= '0;
            rx_dst_q <= '0;
            rx_type_q <= '0;
        end else begin
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // Header of the frame now being read
            if (rx_word_ready && rx_word_first) begin
                rx_src_q <= rx_hdr_src_mac;
                rx_dst_q <= rx_hdr_dst_mac;
                rx_type_q <= rx_hdr_type;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= '0;
            rresp <= resp_okay;
            if (rd_bad) begin
                rresp <= resp_slverr;
            end else begin
                case (rd_idx)
                    reg_src_mac: rdata <= {{(bus_width - mac_width){1'b0}}, hdr_src_mac};
                    reg_dst_type: rdata <= {hdr_type, hdr_dst_mac};
                    reg_rx_src: rdata <= {{(bus_width - mac_width){1'b0}}, rx_src_q};
                    reg_rx_dst_type: rdata <= {rx_type_q, rx_dst_q};
                    reg_rx_data: rdata <= rx_word_valid ? rx_word.raw : '0;
                    default: rresp <= resp_slverr;
                endcase
            end
        end
    end

    // Responses hold until accepted
    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== test/eth_bridge_checker.sv ====
`timescale 1ns/1ps

module eth_bridge_checker (
    input logic       clk,
    input logic       rst,
    input logic [7:0] tx_byte_data,
    input logic       tx_byte_valid,
    input logic       tx_byte_last,
    input logic       tx_byte_ready
);
    import eth_pkg::*;

    // Expected transmit bytes as {last, data} and expected receive words
    logic [8:0]  exp_tx [$];
    logic [63:0] exp_rx [$];
    logic [8:0]  tx_exp;
    int errors = 0;
    int test_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // Header bytes go out high byte first and payload from the low byte
    function automatic void build_frame(input logic [47:0] dst, input logic [47:0] src,
                                        input logic [15:0] etype, input logic [55:0] data [4],
                                        input int counts [4], input int nwords);
        logic [111:0] hdr;
        hdr = {dst, src, etype};
        for (int i = 0; i < hdr_bytes; i++) begin
            exp_tx.push_back({1'b0, hdr[111 - 8 * i -: 8]});
        end
        for (int w = 0; w < nwords; w++) begin
            for (int b = 0; b < counts[w]; b++) begin
                exp_tx.push_back({w == nwords - 1 && b == counts[w] - 1, data[w][8 * b +: 8]});
            end
        end
    endfunction

    // Payload after the header is cut into words of up to 7 bytes
    function automatic void pack_rx_words(input logic [7:0] bytes [$]);
        eth_word_fields_t w;
        int n;
        n = 0;
        w = '0;
        if (bytes.size() < hdr_bytes) begin
            return;
        end
        for (int i = hdr_bytes; i < bytes.size(); i++) begin
            w.data[8 * n +: 8] = bytes[i];
            n++;
            if (n == word_bytes || i == bytes.size() - 1) begin
                w.valid = 1'b1;
                w.last = i == bytes.size() - 1;
                w.count = count_width'(n);
                exp_rx.push_back(w);
                w = '0;
                n = 0;
            end
        end
        if (bytes.size() == hdr_bytes) begin
            w.valid = 1'b1;
            w.last = 1'b1;
            exp_rx.push_back(w);
        end
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (exp !== act) begin
            $display("Error %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_rx(input logic [63:0] act);
        if (exp_rx.size() == 0) begin
            $display("Receive word read when none was expected");
            errors++;
        end else begin
            compare_value("rdata", exp_rx.pop_front(), act);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic report_counts();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
    endtask

    // Transmit stream monitor
    always @(posedge clk) begin
        if (!rst && tx_byte_valid && tx_byte_ready) begin
            if (exp_tx.size() == 0) begin
                $display("Unexpected byte on the transmit stream");
                errors++;
            end else begin
                tx_exp = exp_tx.pop_front();
                compare_value("tx_byte_data", 64'(tx_exp[7:0]), 64'(tx_byte_data));
                compare_value("tx_byte_last", 64'(tx_exp[8]), 64'(tx_byte_last));
            end
        end
    end

endmodule

// ==== test/tb_eth_mmio_bridge.sv ====
`timescale 1ns/1ps

module tb_eth_mmio_bridge;
    import eth_pkg::*;
    import axi4lite_pkg::*;

    // Worst case bytes over all frames sets the cycle limit
    localparam int stream_bytes = 4 * 35 + 4 * 34 + 10;
    localparam int cycle_limit = 20 * stream_bytes + 2000;

    logic        clk;
    logic        rst;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  tx_byte_data;
    logic        tx_byte_valid;
    logic        tx_byte_last;
    logic        tx_byte_ready;
    logic [7:0]  rx_byte_data;
    logic        rx_byte_valid;
    logic        rx_byte_last;
    logic        rx_byte_ready;
    int          cycles = 0;

    eth_mmio_bridge #(.addr_width(12)) eth_mmio_bridge_inst (.*);

    eth_bridge_checker checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // Random gaps on the transmit stream
    always @(negedge clk) begin
        tx_byte_ready = ($urandom % 4) != 0;
    end

    task automatic axi_write(input int idx, input logic [63:0] data, output logic [1:0] resp);
        logic take_aw;
        logic take_w;
        logic take_b;
        awaddr = 12'(idx << word_shift);
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b1;
        forever begin
            take_aw = awvalid && awready;
            take_w = wvalid && wready;
            take_b = bvalid;
            resp = bresp;
            @(negedge clk);
            if (take_aw) awvalid = 1'b0;
            if (take_w) wvalid = 1'b0;
            if (take_b) break;
        end
        bready = 1'b0;
    endtask

    task automatic axi_read(input int idx, output logic [63:0] data, output logic [1:0] resp);
        logic take_ar;
        logic take_r;
        araddr = 12'(idx << word_shift);
        arvalid = 1'b1;
        rready = 1'b1;
        forever begin
            take_ar = arvalid && arready;
            take_r = rvalid;
            data = rdata;
            resp = rresp;
            @(negedge clk);
            if (take_ar) arvalid = 1'b0;
            if (take_r) break;
        end
        rready = 1'b0;
    endtask

    task automatic read_expect(input int idx, input logic [63:0] exp, input logic [1:0] exp_resp);
        logic [63:0] d;
        logic [1:0]  r;
        axi_read(idx, d, r);
        checker_inst.compare_value("rresp", 64'(exp_resp), 64'(r));
        if (exp_resp == resp_okay) checker_inst.compare_value("rdata", exp, d);
    endtask

    task automatic send_rx(input logic [7:0] bytes [$]);
        logic take;
        for (int i = 0; i < bytes.size(); i++) begin
            rx_byte_data = bytes[i];
            rx_byte_last = i == bytes.size() - 1;
            rx_byte_valid = 1'b1;
            forever begin
                take = rx_byte_ready;
                @(negedge clk);
                if (take) break;
            end
        end
        rx_byte_valid = 1'b0;
        rx_byte_last = 1'b0;
    endtask

    initial begin
        logic [1:0]  r;
        logic [63:0] d;
        logic [47:0] dst;
        logic [47:0] src;
        logic [15:0] etype;
        logic [55:0] words [4];
        int          counts [4];
        int          nwords;
        logic [7:0]  frame [$];
        int          len;

        void'($urandom(58802));
        {awaddr, awvalid, wdata, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        {rx_byte_data, rx_byte_valid, rx_byte_last} = '0;
        wstrb = 8'hff;
        tx_byte_ready = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_expect(reg_src_mac, 64'h0, resp_okay);
        read_expect(reg_dst_type, 64'h0, resp_okay);
        read_expect(reg_rx_src, 64'h0, resp_okay);
        read_expect(reg_rx_dst_type, 64'h0, resp_okay);
        read_expect(reg_rx_data, 64'h0, resp_okay);
        checker_inst.finish_test("reset values");

        axi_write(reg_src_mac, 64'hffff_1122_3344_5566, r);
        checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
        read_expect(reg_src_mac, 64'h0000_1122_3344_5566, resp_okay);
        axi_write(reg_dst_type, 64'h88b5_a1b2_c3d4_e5f6, r);
        checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
        read_expect(reg_dst_type, 64'h88b5_a1b2_c3d4_e5f6, resp_okay);
        axi_write(6, 64'h1234, r);
        checker_inst.compare_value("bresp", 64'(resp_slverr), 64'(r));
        read_expect(6, 64'h0, resp_slverr);
        read_expect(reg_tx_data, 64'h0, resp_slverr);
        read_expect(64, 64'h0, resp_slverr);
        axi_write(reg_rx_src, 64'h5555_5555, r);
        checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
        read_expect(reg_rx_src, 64'h0, resp_okay);
        checker_inst.finish_test("register map");

        for (int f = 0; f < 4; f++) begin
            dst = {$urandom, $urandom};
            src = {$urandom, $urandom};
            etype = 16'($urandom);
            nwords = 1 + $urandom % 3;
            for (int w = 0; w < 4; w++) begin
                words[w] = {$urandom, $urandom};
                counts[w] = 1 + $urandom % 7;
            end
            axi_write(reg_src_mac, {16'h0, src}, r);
            checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
            axi_write(reg_dst_type, {etype, dst}, r);
            checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
            checker_inst.build_frame(dst, src, etype, words, counts, nwords);
            for (int w = 0; w < nwords; w++) begin
                axi_write(reg_tx_data, {1'b1, w == nwords - 1, 3'b0, 3'(counts[w]), words[w]}, r);
                checker_inst.compare_value("bresp", 64'(resp_okay), 64'(r));
            end
            while (checker_inst.exp_tx.size() > 0) @(negedge clk);
        end
        checker_inst.finish_test("transmit frames");

        for (int f = 0; f < 4; f++) begin
            frame.delete();
            len = hdr_bytes + 1 + $urandom % 20;
            for (int i = 0; i < len; i++) frame.push_back(8'($urandom));
            checker_inst.pack_rx_words(frame);
            fork
                send_rx(frame);
                while (checker_inst.exp_rx.size() > 0) begin
                    axi_read(reg_rx_data, d, r);
                    checker_inst.compare_value("rresp", 64'(resp_okay), 64'(r));
                    if (d[63]) begin
                        checker_inst.compare_rx(d);
                    end else begin
                        checker_inst.compare_value("rdata", 64'h0, d);
                    end
                end
            join
            read_expect(reg_rx_src, {16'h0, frame[6], frame[7], frame[8], frame[9],
                                     frame[10], frame[11]}, resp_okay);
            read_expect(reg_rx_dst_type, {frame[12], frame[13], frame[0], frame[1], frame[2],
                                          frame[3], frame[4], frame[5]}, resp_okay);
        end
        checker_inst.finish_test("receive frames");

        frame.delete();
        for (int i = 0; i < 10; i++) frame.push_back(8'($urandom));
        send_rx(frame);
        repeat (2) @(negedge clk);
        read_expect(reg_rx_data, 64'h0, resp_okay);
        checker_inst.finish_test("short frame");

        checker_inst.report_counts();
        if (checker_inst.errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/eth_pkg.sv
common/axi4lite_pkg.sv
mmio/eth_mmio_regs.sv
verilog/eth_tx_framer.sv
verilog/eth_rx_parser.sv
verilog/eth_mmio_bridge.sv
test/eth_bridge_checker.sv
test/tb_eth_mmio_bridge.sv

// ==== verilog/eth_mmio_bridge.sv ====
`timescale 1ns/1ps

module eth_mmio_bridge #(
    parameter int addr_width = 12
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [addr_width-1:0]                 awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [axi4lite_pkg::bus_width-1:0]    wdata,
    input  logic [axi4lite_pkg::bus_width/8-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [addr_width-1:0]                 araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [axi4lite_pkg::bus_width-1:0]    rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [7:0]                            tx_byte_data,
    output logic                                  tx_byte_valid,
    output logic                                  tx_byte_last,
    input  logic                                  tx_byte_ready,
    input  logic [7:0]                            rx_byte_data,
    input  logic                                  rx_byte_valid,
    input  logic                                  rx_byte_last,
    output logic                                  rx_byte_ready
);
    import eth_pkg::*;

    // Transmit header and word path
    logic [mac_width-1:0]   hdr_dst_mac;
    logic [mac_width-1:0]   hdr_src_mac;
    logic [type_width-1:0]  hdr_type;
    logic                   tx_word_valid;
    logic [data_width-1:0]  tx_word_data;
    logic [count_width-1:0] tx_word_count;
    logic                   tx_word_last;
    logic                   tx_word_ready;

    // Receive word path
    logic                   rx_word_valid;
    logic [data_width-1:0]  rx_word_data;
    logic [count_width-1:0] rx_word_count;
    logic                   rx_word_last;
    logic                   rx_word_first;
    logic [mac_width-1:0]   rx_hdr_dst_mac;
    logic [mac_width-1:0]   rx_hdr_src_mac;
    logic [type_width-1:0]  rx_hdr_type;
    logic                   rx_word_ready;

    eth_mmio_regs #(
        .addr_width(addr_width)
    ) eth_mmio_regs_inst (.*);

    eth_tx_framer eth_tx_framer_inst (.*);

    eth_rx_parser eth_rx_parser_inst (.*);

endmodule

// ==== verilog/eth_rx_parser.sv ====
`timescale 1ns/1ps

module eth_rx_parser (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [7:0]                       rx_byte_data,
    input  logic                             rx_byte_valid,
    input  logic                             rx_byte_last,
    output logic                             rx_byte_ready,
    output logic                             rx_word_valid,
    output logic [eth_pkg::data_width-1:0]   rx_word_data,
    output logic [eth_pkg::count_width-1:0]  rx_word_count,
    output logic                             rx_word_last,
    output logic                             rx_word_first,
    output logic [eth_pkg::mac_width-1:0]    rx_hdr_dst_mac,
    output logic [eth_pkg::mac_width-1:0]    rx_hdr_src_mac,
    output logic [eth_pkg::type_width-1:0]   rx_hdr_type,
    input  logic                             rx_word_ready
);
    import eth_pkg::*;

    localparam int hdr_bits = 2 * mac_width + type_width;
    localparam int hcnt_width = $clog2(hdr_bytes + 1);

    logic [hcnt_width-1:0] hdr_cnt;
    logic [hdr_bits-1:0]   hdr_q;
    logic [count_width:0]  fill;
    logic                  hdr_done;
    logic                  byte_hs;

    // Stall the byte stream while a finished word waits
    assign rx_byte_ready = !rx_word_valid;
    assign byte_hs = rx_byte_valid && rx_byte_ready;
    assign hdr_done = hdr_cnt == hdr_bytes;

    assign rx_word_count = fill[count_width-1:0];
    assign rx_hdr_dst_mac = hdr_q[hdr_bits-1 -: mac_width];
    assign rx_hdr_src_mac = hdr_q[type_width +: mac_width];
    assign rx_hdr_type = hdr_q[type_width-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_cnt <= '0;
            fill <= '0;
            rx_word_valid <= 1'b0;
            rx_word_last <= 1'b0;
            rx_word_first <= 1'b0;
            rx_word_data <= '0;
        end else if (rx_word_ready) begin
            rx_word_valid <= 1'b0;
            rx_word_last <= 1'b0;
            rx_word_first <= 1'b0;
            rx_word_data <= '0;
            fill <= '0;
        end else if (byte_hs && !hdr_done) begin
            // Last header byte marks the next word as the frame's first
            if (hdr_cnt == hdr_bytes - 1) begin
                rx_word_first <= 1'b1;
                rx_word_valid <= rx_byte_last;
                rx_word_last <= rx_byte_last;
            end
            // Short frame drops back to header search
            if (rx_byte_last) begin
                hdr_cnt <= '0;
            end else begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
        end else if (byte_hs) begin
            rx_word_data[fill[count_width-1:0] * 8 +: 8] <= rx_byte_data;
            fill <= fill + 1'b1;
            if (rx_byte_last || fill == word_bytes - 1) begin
                rx_word_valid <= 1'b1;
            end
            if (rx_byte_last) begin
                rx_word_last <= 1'b1;
                hdr_cnt <= '0;
            end
        end
    end

    // Header bytes shift in from the low end, so byte 0 ends up on top
    always_ff @(posedge clk) begin
        if (byte_hs && !hdr_done) begin
            hdr_q <= {hdr_q[hdr_bits-9:0], rx_byte_data};
        end
    end

    assert property (@(posedge clk) disable iff (rst) fill <= word_bytes);

endmodule

// ==== verilog/eth_tx_framer.sv ====
`timescale 1ns/1ps

module eth_tx_framer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [eth_pkg::mac_width-1:0]    hdr_dst_mac,
    input  logic [eth_pkg::mac_width-1:0]    hdr_src_mac,
    input  logic [eth_pkg::type_width-1:0]   hdr_type,
    input  logic                             tx_word_valid,
    input  logic [eth_pkg::data_width-1:0]   tx_word_data,
    input  logic [eth_pkg::count_width-1:0]  tx_word_count,
    input  logic                             tx_word_last,
    output logic                             tx_word_ready,
    output logic [7:0]                       tx_byte_data,
    output logic                             tx_byte_valid,
    output logic                             tx_byte_last,
    input  logic                             tx_byte_ready
);
    import eth_pkg::*;

    localparam int hdr_bits = 2 * mac_width + type_width;
    localparam int idx_width = $clog2(hdr_bytes + word_bytes + 1);

    logic                   frame_active;
    logic [hdr_bits-1:0]    hdr_q;
    logic                   buf_valid;
    logic [data_width-1:0]  buf_data;
    logic [count_width-1:0] buf_count;
    logic                   buf_last;
    logic [idx_width-1:0]   byte_idx;
    logic [idx_width-1:0]   end_idx;
    logic                   in_hdr;
    logic                   final_byte;
    logic                   word_hs;
    logic                   byte_hs;

    // Positions 0 to 13 are header bytes and payload follows
    assign end_idx = idx_width'(hdr_bytes) + idx_width'(buf_count);
    assign in_hdr = byte_idx < idx_width'(hdr_bytes);
    assign final_byte = byte_idx == end_idx - 1'b1;

    assign tx_word_ready = !buf_valid;
    assign word_hs = tx_word_valid && tx_word_ready;

    assign tx_byte_valid = buf_valid && byte_idx < end_idx;
    assign tx_byte_data = in_hdr ? hdr_q[hdr_bits-1 -: 8] : buf_data[7:0];
    assign tx_byte_last = buf_last && final_byte;
    assign byte_hs = tx_byte_valid && tx_byte_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            buf_valid <= 1'b0;
            byte_idx <= '0;
        end else if (word_hs) begin
            buf_valid <= 1'b1;
            frame_active <= !tx_word_last;
            // Only the first word of a frame sends the header
            byte_idx <= frame_active ? idx_width'(hdr_bytes) : '0;
        end else if (byte_hs) begin
            byte_idx <= byte_idx + 1'b1;
            if (final_byte) begin
                buf_valid <= 1'b0;
            end
        end else if (buf_valid && !tx_byte_valid) begin
            // Empty middle word has nothing to send
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (word_hs) begin
            buf_data <= tx_word_data;
            buf_count <= tx_word_count;
            buf_last <= tx_word_last;
            if (!frame_active) begin
                hdr_q <= {hdr_dst_mac, hdr_src_mac, hdr_type};
            end
        end else if (byte_hs) begin
            if (in_hdr) begin
                hdr_q <= hdr_q << 8;
            end else begin
                buf_data <= buf_data >> 8;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        tx_byte_valid && !tx_byte_ready |=> tx_byte_valid && $stable(tx_byte_data));

endmodule
